// ==== hdl/core_pkg.sv ====
/*
 * Core package
 * Shared definitions for the multi-cycle RV32I core: major opcodes,
 * ALU function codes, sequencer states and the reset address.
 */

package core_pkg;

  // Register index width
  localparam int REG_ADDR_W = 5;

  // Reset PC and instruction memory base
  localparam logic [31:0] RESET_PC = 32'h01000000;

  // Full encoding of EBREAK
  localparam logic [31:0] EBREAK_INSN = 32'h00100073;

  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_LUI    = 7'b0110111,
    OPC_BRANCH = 7'b1100011,
    OPC_SYSTEM = 7'b1110011
  } opcode_e;

  typedef enum logic [3:0] {
    ALU_ADD    = 4'd0,
    ALU_SUB    = 4'd1,
    ALU_SLL    = 4'd2,
    ALU_SLT    = 4'd3,
    ALU_SLTU   = 4'd4,
    ALU_XOR    = 4'd5,
    ALU_SRL    = 4'd6,
    ALU_SRA    = 4'd7,
    ALU_OR     = 4'd8,
    ALU_AND    = 4'd9,
    ALU_PASS_B = 4'd10
  } alu_op_e;

  typedef enum logic [2:0] {
    ST_IDLE      = 3'd0,
    ST_FETCH     = 3'd1,
    ST_DECODE    = 3'd2,
    ST_EXECUTE   = 3'd3,
    ST_WRITEBACK = 3'd4,
    ST_HALT      = 3'd5
  } seq_state_e;

endpackage : core_pkg

// ==== hdl/decode_if.sv ====
/*
 * Decode bus
 * Carries the decoded instruction fields and control bits from the
 * decoder to the sequencer, register file and ALU.
 */

`timescale 1ns/10ps

interface decode_if #(
  parameter int DWIDTH = 32
);

  logic [core_pkg::REG_ADDR_W-1:0] rd;
  logic [core_pkg::REG_ADDR_W-1:0] rs1;
  logic [core_pkg::REG_ADDR_W-1:0] rs2;
  logic [2:0]                      funct3;
  logic [DWIDTH-1:0]               imm;
  core_pkg::alu_op_e               alu_op;
  logic                            use_imm;
  logic                            reg_write;
  logic                            is_branch;
  logic                            is_halt;

  modport producer (
    output rd, rs1, rs2, funct3, imm, alu_op,
    output use_imm, reg_write, is_branch, is_halt
  );

  modport consumer (
    input rd, rs1, rs2, funct3, imm, alu_op,
    input use_imm, reg_write, is_branch, is_halt
  );

endinterface : decode_if

// ==== hdl/pc_counter.sv ====
/*
 * Program counter
 * Holds the PC of the current instruction. Loads a branch target when
 * told to, otherwise steps to the next word.
 */

`timescale 1ns/10ps

module pc_counter
  import core_pkg::*;
#(
  parameter int              AWIDTH   = 32,
  parameter logic [31:0]     BASEADDR = RESET_PC
) (
  input  logic              clk,
  input  logic              rst_n_i,
  input  logic              step_i,
  input  logic              load_i,
  input  logic [AWIDTH-1:0] target_i,
  output logic [AWIDTH-1:0] pc_o
);

  logic [AWIDTH-1:0] pc_q;

  // Branch target wins over the sequential step
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pc_q <= AWIDTH'(BASEADDR);
    end else if (load_i) begin
      pc_q <= target_i;
    end else if (step_i) begin
      pc_q <= pc_q + AWIDTH'(4);
    end
  end

  assign pc_o = pc_q;

endmodule : pc_counter

// ==== hdl/core_sequencer.sv ====
/*
 * Core sequencer
 * Steps every instruction through fetch, decode, execute and
 * writeback, one cycle each, with one enable per state. Leaves
 * decode for a permanent halt when the instruction is EBREAK.
 */

`timescale 1ns/10ps

module core_sequencer
  import core_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n_i,
  input  logic     run_i,
  decode_if.consumer dec,
  output logic     fetch_en_o,
  output logic     decode_en_o,
  output logic     exec_en_o,
  output logic     wb_en_o,
  output logic     halted_o
);

  seq_state_e state_q;
  seq_state_e state_d;

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: begin
        if (run_i) begin
          state_d = ST_FETCH;
        end
      end
      ST_FETCH:     state_d = ST_DECODE;
      // Fields are valid here, so EBREAK is caught before execute
      ST_DECODE:    state_d = dec.is_halt ? ST_HALT : ST_EXECUTE;
      ST_EXECUTE:   state_d = ST_WRITEBACK;
      ST_WRITEBACK: state_d = ST_FETCH;
      // Only reset leaves HALT
      ST_HALT:      state_d = ST_HALT;
      default:      state_d = ST_IDLE;
    endcase
  end

  // One enable per state
  assign fetch_en_o  = (state_q == ST_FETCH);
  assign decode_en_o = (state_q == ST_DECODE);
  assign exec_en_o   = (state_q == ST_EXECUTE);
  assign wb_en_o     = (state_q == ST_WRITEBACK);
  assign halted_o    = (state_q == ST_HALT);

endmodule : core_sequencer

// ==== hdl/insn_memory.sv ====
/*
 * Instruction memory
 * Word-addressed RAM. Filled through the load port before the core
 * runs; the fetch port registers the word at the PC.
 */

`timescale 1ns/10ps

module insn_memory
  import core_pkg::*;
#(
  parameter int          AWIDTH     = 32,
  parameter int          DWIDTH     = 32,
  parameter logic [31:0] BASEADDR   = RESET_PC,
  parameter int          IMEM_WORDS = 256
) (
  input  logic                          clk,
  input  logic                          load_we_i,
  input  logic [$clog2(IMEM_WORDS)-1:0] load_addr_i,
  input  logic [DWIDTH-1:0]             load_data_i,
  input  logic                          fetch_en_i,
  input  logic [AWIDTH-1:0]             pc_i,
  output logic [DWIDTH-1:0]             insn_o
);

  localparam int IDX_W = $clog2(IMEM_WORDS);

  logic [DWIDTH-1:0] mem [IMEM_WORDS];
  logic [AWIDTH-1:0] pc_off;
  logic [IDX_W-1:0]  fetch_idx;

  // Byte offset from the base, then drop the two byte bits
  assign pc_off    = pc_i - AWIDTH'(BASEADDR);
  assign fetch_idx = pc_off[IDX_W+1:2];

  always_ff @(posedge clk) begin
    if (load_we_i) begin
      mem[load_addr_i] <= load_data_i;
    end
    if (fetch_en_i) begin
      insn_o <= mem[fetch_idx];
    end
  end

endmodule : insn_memory

// ==== hdl/decode.sv ====
/*
 * Instruction decoder
 * Holds the instruction register, splits out the register fields,
 * builds the I, B or U immediate and derives the control bits for
 * the OP, OP-IMM, LUI, BRANCH and EBREAK instructions.
 */

`timescale 1ns/10ps

module decode
  import core_pkg::*;
#(
  parameter int DWIDTH = 32
) (
  input  logic              clk,
  input  logic              rst_n_i,
  input  logic              decode_en_i,
  input  logic [DWIDTH-1:0] insn_i,
  decode_if.producer        dec
);

  // addi x0, x0, 0
  localparam logic [DWIDTH-1:0] NOP_INSN = DWIDTH'(32'h00000013);

  logic [DWIDTH-1:0] ir_q;
  logic [DWIDTH-1:0] insn;
  logic [6:0]        opcode;
  logic [6:0]        funct7;

  function automatic alu_op_e alu_sel(input logic [2:0] f3, input logic alt);
    alu_op_e op;
    case (f3)
      3'b000:  op = alt ? ALU_SUB : ALU_ADD;
      3'b001:  op = ALU_SLL;
      3'b010:  op = ALU_SLT;
      3'b011:  op = ALU_SLTU;
      3'b100:  op = ALU_XOR;
      3'b101:  op = alt ? ALU_SRA : ALU_SRL;
      3'b110:  op = ALU_OR;
      default: op = ALU_AND;
    endcase
    return op;
  endfunction

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ir_q <= NOP_INSN;
    end else if (decode_en_i) begin
      ir_q <= insn_i;
    end
  end

  // Memory output during DECODE, the held IR afterwards
  assign insn   = decode_en_i ? insn_i : ir_q;
  assign opcode = insn[6:0];
  assign funct7 = insn[31:25];

  assign dec.rd     = insn[11:7];
  assign dec.rs1    = insn[19:15];
  assign dec.rs2    = insn[24:20];
  assign dec.funct3 = insn[14:12];

  always_comb begin
    dec.imm       = '0;
    dec.alu_op    = ALU_ADD;
    dec.use_imm   = 1'b0;
    dec.reg_write = 1'b0;
    dec.is_branch = 1'b0;
    dec.is_halt   = 1'b0;
    case (opcode)
      OPC_OP: begin
        dec.alu_op    = alu_sel(insn[14:12], funct7[5]);
        dec.reg_write = 1'b1;
      end
      OPC_OP_IMM: begin
        dec.imm       = {{(DWIDTH-12){insn[31]}}, insn[31:20]};
        // funct7 only selects srai; addi has no subtract form
        dec.alu_op    = alu_sel(insn[14:12], (insn[14:12] == 3'b101) && funct7[5]);
        dec.use_imm   = 1'b1;
        dec.reg_write = 1'b1;
      end
      OPC_LUI: begin
        dec.imm       = {{(DWIDTH-32){insn[31]}}, insn[31:12], 12'b0};
        dec.alu_op    = ALU_PASS_B;
        dec.use_imm   = 1'b1;
        dec.reg_write = 1'b1;
      end
      OPC_BRANCH: begin
        dec.imm       = {{(DWIDTH-12){insn[31]}}, insn[7], insn[30:25], insn[11:8], 1'b0};
        dec.alu_op    = ALU_SUB;
        dec.is_branch = 1'b1;
      end
      OPC_SYSTEM: begin
        dec.is_halt = (insn == DWIDTH'(EBREAK_INSN));
      end
      default: begin
        // Unsupported opcode falls through as a no-op
        dec.reg_write = 1'b0;
      end
    endcase
  end

endmodule : decode

// ==== hdl/register_file.sv ====
/*
 * Register file
 * 32 integer registers with two combinational read ports and one
 * write port. x0 always reads as zero.
 */

`timescale 1ns/10ps

module register_file
  import core_pkg::*;
#(
  parameter int DWIDTH = 32
) (
  input  logic              clk,
  input  logic              rst_n_i,
  decode_if.consumer        dec,
  input  logic              we_i,
  input  logic [DWIDTH-1:0] wdata_i,
  output logic [DWIDTH-1:0] rs1data_o,
  output logic [DWIDTH-1:0] rs2data_o
);

  localparam int NREGS = 2 ** REG_ADDR_W;

  logic [DWIDTH-1:0] regs [NREGS];

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we_i && (dec.rd != '0)) begin
      regs[dec.rd] <= wdata_i;
    end
  end

  assign rs1data_o = (dec.rs1 == '0) ? '0 : regs[dec.rs1];
  assign rs2data_o = (dec.rs2 == '0) ? '0 : regs[dec.rs2];

endmodule : register_file

// ==== hdl/alu.sv ====
/*
 * ALU
 * Computes the arithmetic or logic result, the branch decision and
 * the branch target, and registers all three on the execute enable.
 */

`timescale 1ns/10ps

module alu
  import core_pkg::*;
#(
  parameter int DWIDTH = 32,
  parameter int AWIDTH = 32
) (
  input  logic              clk,
  input  logic              rst_n_i,
  input  logic              exec_en_i,
  decode_if.consumer        dec,
  input  logic [AWIDTH-1:0] pc_i,
  input  logic [DWIDTH-1:0] rs1_i,
  input  logic [DWIDTH-1:0] rs2_i,
  output logic [DWIDTH-1:0] res_o,
  output logic              br_taken_o,
  output logic [AWIDTH-1:0] target_o
);

  logic [DWIDTH-1:0] op_b;
  logic [4:0]        shamt;
  logic [DWIDTH-1:0] res_d;
  logic              cond;

  assign op_b  = dec.use_imm ? dec.imm : rs2_i;
  assign shamt = op_b[4:0];

  always_comb begin
    case (dec.alu_op)
      ALU_ADD:    res_d = rs1_i + op_b;
      ALU_SUB:    res_d = rs1_i - op_b;
      ALU_SLL:    res_d = rs1_i << shamt;
      ALU_SLT:    res_d = DWIDTH'($signed(rs1_i) < $signed(op_b));
      ALU_SLTU:   res_d = DWIDTH'(rs1_i < op_b);
      ALU_XOR:    res_d = rs1_i ^ op_b;
      ALU_SRL:    res_d = rs1_i >> shamt;
      ALU_SRA:    res_d = $unsigned($signed(rs1_i) >>> shamt);
      ALU_OR:     res_d = rs1_i | op_b;
      ALU_AND:    res_d = rs1_i & op_b;
      ALU_PASS_B: res_d = op_b;
      default:    res_d = '0;
    endcase
  end

  // Branch compare always works on the two registers
  always_comb begin
    case (dec.funct3)
      3'b000:  cond = (rs1_i == rs2_i);
      3'b001:  cond = (rs1_i != rs2_i);
      3'b100:  cond = ($signed(rs1_i) < $signed(rs2_i));
      3'b101:  cond = ($signed(rs1_i) >= $signed(rs2_i));
      3'b110:  cond = (rs1_i < rs2_i);
      3'b111:  cond = (rs1_i >= rs2_i);
      default: cond = 1'b0;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      res_o      <= '0;
      br_taken_o <= 1'b0;
      target_o   <= '0;
    end else if (exec_en_i) begin
      res_o      <= res_d;
      br_taken_o <= dec.is_branch && cond;
      target_o   <= pc_i + AWIDTH'(dec.imm);
    end
  end

endmodule : alu

// ==== hdl/pd_core.sv ====
/*
 * Processor core top level
 * Multi-cycle RV32I integer core. Connects the sequencer, PC,
 * instruction memory, decoder, register file and ALU, and exposes
 * the program load port, the run level, the retire trace and halt.
 */

`timescale 1ns/10ps

module pd_core
  import core_pkg::*;
#(
  parameter int          AWIDTH     = 32,
  parameter int          DWIDTH     = 32,
  parameter logic [31:0] BASEADDR   = RESET_PC,
  parameter int          IMEM_WORDS = 256
) (
  input  logic                          clk,
  input  logic                          rst_n_i,
  input  logic                          load_we_i,
  input  logic [$clog2(IMEM_WORDS)-1:0] load_addr_i,
  input  logic [DWIDTH-1:0]             load_data_i,
  input  logic                          run_i,
  output logic                          retire_o,
  output logic [AWIDTH-1:0]             retire_pc_o,
  output logic [REG_ADDR_W-1:0]         retire_rd_o,
  output logic                          retire_we_o,
  output logic [DWIDTH-1:0]             retire_data_o,
  output logic                          halted_o
);

  logic              fetch_en;
  logic              decode_en;
  logic              exec_en;
  logic              wb_en;
  logic              imem_we;
  logic              rf_we;
  logic              pc_load;
  logic [AWIDTH-1:0] pc;
  logic [DWIDTH-1:0] insn;
  logic [DWIDTH-1:0] rs1_data;
  logic [DWIDTH-1:0] rs2_data;
  logic [DWIDTH-1:0] alu_res;
  logic              br_taken;
  logic [AWIDTH-1:0] br_target;

  decode_if #(.DWIDTH(DWIDTH)) dec_bus ();

  // Program loading is locked out while the core runs
  assign imem_we = load_we_i && !run_i;
  assign rf_we   = wb_en && dec_bus.reg_write;
  assign pc_load = wb_en && br_taken;

  core_sequencer u_seq (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .run_i       (run_i),
    .dec         (dec_bus.consumer),
    .fetch_en_o  (fetch_en),
    .decode_en_o (decode_en),
    .exec_en_o   (exec_en),
    .wb_en_o     (wb_en),
    .halted_o    (halted_o)
  );

  pc_counter #(.AWIDTH(AWIDTH), .BASEADDR(BASEADDR)) u_pc (
    .clk      (clk),
    .rst_n_i  (rst_n_i),
    .step_i   (wb_en),
    .load_i   (pc_load),
    .target_i (br_target),
    .pc_o     (pc)
  );

  insn_memory #(
    .AWIDTH     (AWIDTH),
    .DWIDTH     (DWIDTH),
    .BASEADDR   (BASEADDR),
    .IMEM_WORDS (IMEM_WORDS)
  ) u_imem (
    .clk         (clk),
    .load_we_i   (imem_we),
    .load_addr_i (load_addr_i),
    .load_data_i (load_data_i),
    .fetch_en_i  (fetch_en),
    .pc_i        (pc),
    .insn_o      (insn)
  );

  decode #(.DWIDTH(DWIDTH)) u_dec (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .decode_en_i (decode_en),
    .insn_i      (insn),
    .dec         (dec_bus.producer)
  );

  register_file #(.DWIDTH(DWIDTH)) u_rf (
    .clk       (clk),
    .rst_n_i   (rst_n_i),
    .dec       (dec_bus.consumer),
    .we_i      (rf_we),
    .wdata_i   (alu_res),
    .rs1data_o (rs1_data),
    .rs2data_o (rs2_data)
  );

  alu #(.DWIDTH(DWIDTH), .AWIDTH(AWIDTH)) u_alu (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .exec_en_i  (exec_en),
    .dec        (dec_bus.consumer),
    .pc_i       (pc),
    .rs1_i      (rs1_data),
    .rs2_i      (rs2_data),
    .res_o      (alu_res),
    .br_taken_o (br_taken),
    .target_o   (br_target)
  );

  // Retire trace, valid in the writeback cycle
  assign retire_o      = wb_en;
  assign retire_pc_o   = pc;
  assign retire_rd_o   = dec_bus.rd;
  assign retire_we_o   = dec_bus.reg_write;
  assign retire_data_o = alu_res;

endmodule : pd_core

// ==== tests/clk_gen.sv ====
/*
 * Testbench clock and reset
 * 10 ns clock; active-low reset held for the first three cycles.
 */

`timescale 1ns/10ps

module clk_gen #(
  parameter int HALF_PERIOD  = 5,
  parameter int RESET_CYCLES = 3
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(HALF_PERIOD) clk_o = ~clk_o;
  end

  initial begin
    rst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    rst_n_o <= 1'b1;
  end

endmodule : clk_gen

// ==== tests/pd_core_tb.sv ====
/*
 * Core testbench
 * Loads a program from the stimulus file, runs the core until
 * EBREAK and checks every retire record, the 4-cycle retire spacing,
 * the halt timing and the total number of retires.
 */

`timescale 1ns/10ps

module pd_core_tb
  import core_pkg::*;
();

  localparam int IMEM_WORDS   = 256;
  localparam int ADDR_W       = $clog2(IMEM_WORDS);
  localparam int STIM_AW      = 8;
  // Stimulus layout is length at 0, program from 1, records, then count
  localparam int REC_BASE     = 'h40;
  localparam int COUNT_ADDR   = 'hF0;
  localparam int DRAIN_CYCLES = 8;

  logic               clk;
  logic               rst_n;
  logic               load_we;
  logic [ADDR_W-1:0]  load_addr;
  logic [31:0]        load_data;
  logic               run;
  logic               retire;
  logic [31:0]        retire_pc;
  logic [REG_ADDR_W-1:0] retire_rd;
  logic               retire_we;
  logic [31:0]        retire_data;
  logic               halted;

  logic [31:0] stim [2**STIM_AW];

  int prog_len;
  int exp_count;
  int limit;
  int run_errors;
  int total_errors;
  // Written only by the monitor below
  int mon_errors;
  int retire_count;
  int cycle_no;
  int last_retire;
  logic halted_seen;

  clk_gen u_clk_gen (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  pd_core #(
    .AWIDTH     (32),
    .DWIDTH     (32),
    .BASEADDR   (RESET_PC),
    .IMEM_WORDS (IMEM_WORDS)
  ) DUT (
    .clk           (clk),
    .rst_n_i       (rst_n),
    .load_we_i     (load_we),
    .load_addr_i   (load_addr),
    .load_data_i   (load_data),
    .run_i         (run),
    .retire_o      (retire),
    .retire_pc_o   (retire_pc),
    .retire_rd_o   (retire_rd),
    .retire_we_o   (retire_we),
    .retire_data_o (retire_data),
    .halted_o      (halted)
  );

  function automatic logic [31:0] stim_at(input int addr);
    return stim[addr[STIM_AW-1:0]];
  endfunction

  // Compare one retire with its record; rd and data only matter on a write
  task automatic check_retire(input int idx);
    int                    base;
    logic [31:0]           exp_pc;
    logic [REG_ADDR_W-1:0] exp_rd;
    logic                  exp_we;
    logic [31:0]           exp_data;
    base     = REC_BASE + 4 * idx;
    exp_pc   = stim_at(base);
    exp_rd   = REG_ADDR_W'(stim_at(base + 1));
    exp_we   = 1'(stim_at(base + 2));
    exp_data = stim_at(base + 3);
    if (retire_pc !== exp_pc) begin
      mon_errors++;
      $display("[ERROR] retire_pc_o #%0d: expected %h, got %h", idx, exp_pc, retire_pc);
    end
    if (retire_we !== exp_we) begin
      mon_errors++;
      $display("[ERROR] retire_we_o #%0d: expected %h, got %h", idx, exp_we, retire_we);
    end
    if (exp_we) begin
      if (retire_rd !== exp_rd) begin
        mon_errors++;
        $display("[ERROR] retire_rd_o #%0d: expected %h, got %h", idx, exp_rd, retire_rd);
      end
      if (retire_data !== exp_data) begin
        mon_errors++;
        $display("[ERROR] retire_data_o #%0d: expected %h, got %h",
                 idx, exp_data, retire_data);
      end
    end
  endtask

  // Outputs are sampled mid-cycle, away from the rising edge
  always @(negedge clk) begin
    if (!rst_n) begin
      mon_errors   = 0;
      retire_count = 0;
      cycle_no     = 0;
      last_retire  = 0;
      halted_seen  = 1'b0;
    end else begin
      cycle_no++;
      if (retire) begin
        if (halted_seen) begin
          mon_errors++;
          $display("Retire seen after the core halted");
        end
        if (retire_count > 0 && cycle_no - last_retire != 4) begin
          mon_errors++;
          $display("Retire #%0d came %0d cycles after the previous one instead of 4",
                   retire_count, cycle_no - last_retire);
        end
        if (retire_count >= exp_count) begin
          mon_errors++;
          $display("Extra retire beyond the %0d expected", exp_count);
        end else begin
          check_retire(retire_count);
        end
        last_retire = cycle_no;
        retire_count++;
      end
      // WRITEBACK, FETCH and DECODE of EBREAK, then HALT
      if (halted && !halted_seen) begin
        halted_seen = 1'b1;
        if (cycle_no - last_retire != 3) begin
          mon_errors++;
          $display("Halt came %0d cycles after the last retire instead of 3",
                   cycle_no - last_retire);
        end
      end
    end
  end

  task automatic load_program();
    for (int i = 0; i < prog_len; i++) begin
      @(posedge clk);
      load_we   <= 1'b1;
      load_addr <= ADDR_W'(i);
      load_data <= stim_at(1 + i);
    end
    @(posedge clk);
    load_we <= 1'b0;
  endtask

  task automatic wait_for_halt();
    int cycles;
    cycles = 0;
    while (!halted_seen && cycles < limit) begin
      @(posedge clk);
      cycles++;
    end
    if (!halted_seen) begin
      run_errors++;
      $display("Timeout: core did not halt within %0d cycles", limit);
    end
  endtask

  initial begin
    load_we    = 1'b0;
    load_addr  = '0;
    load_data  = '0;
    run        = 1'b0;
    run_errors = 0;
    $readmemh("tests/pd_core_stim.txt", stim);
    prog_len  = stim_at(0);
    exp_count = stim_at(COUNT_ADDR);
    limit     = 4 * prog_len + 50;
    @(posedge rst_n);
    if (prog_len < 1 || prog_len >= REC_BASE) begin
      run_errors++;
      $display("Stimulus file gives no usable program length");
    end else begin
      load_program();
      @(posedge clk);
      run <= 1'b1;
      wait_for_halt();
      repeat (DRAIN_CYCLES) @(posedge clk);
    end
    if (retire_count < exp_count) begin
      run_errors++;
      $display("Too few retires: %0d of %0d expected", retire_count, exp_count);
    end
    total_errors = run_errors + mon_errors;
    $display("Errors: %0d, retires: %0d of %0d expected", total_errors, retire_count, exp_count);
    if (total_errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule : pd_core_tb

// ==== tests/pd_core_stim.txt ====
// @000: program length, then program words (4 per line, word index in comment)
// @040: retire records, one per line: pc rd we data (rd, data unused when we is 0)
// @0F0: expected retire count
@000
0000002D
800000B7 FFB00113 00700193 00310233 // 00 lui x1 / addi x2,-5 / addi x3,7 / add
402182B3 00312333 003133B3 4030D433 // 04 sub / slt / sltu / sra
0030D4B3 00319533 003145B3 00316633 // 08 srl / sll / xor / or
003176B3 FFF12713 FFF1B793 FFF1C813 // 0C and / slti / sltiu / xori -1
0F01E893 0FF17913 01C19993 01C15A13 // 10 ori / andi / slli 28 / srli 28
40115A93 00518013 00300B33 00218463 // 14 srai 1 / addi x0 / add x22,x0,x3 / beq NT
00219463 00100B93 00319463 00318463 // 18 bne T / skip / bne NT / beq T
00100B93 0021C463 00314463 00100B93 // 1C skip / blt NT / blt T / skip
00315463 0021D463 00100B93 00316463 // 20 bge NT / bge T / skip / bltu NT
0021E463 00100B93 0021F463 00317463 // 24 bltu T / skip / bgeu NT / bgeu T
00100B93 00300C13 FFFC0C13 FE0C1EE3 // 28 skip / li x24,3 / addi -1 / bne back
00100073                            // 2C ebreak
@040
01000000 01 1 80000000
01000004 02 1 FFFFFFFB
01000008 03 1 00000007
0100000C 04 1 00000002
01000010 05 1 0000000C
01000014 06 1 00000001
01000018 07 1 00000000
0100001C 08 1 FF000000
01000020 09 1 01000000
01000024 0A 1 00000380
01000028 0B 1 FFFFFFFC
0100002C 0C 1 FFFFFFFF
01000030 0D 1 00000003
01000034 0E 1 00000001
01000038 0F 1 00000001
0100003C 10 1 FFFFFFF8
01000040 11 1 000000F7
01000044 12 1 000000FB
01000048 13 1 70000000
0100004C 14 1 0000000F
01000050 15 1 FFFFFFFD
01000054 00 1 0000000C
01000058 16 1 00000007
0100005C 00 0 00000000
01000060 00 0 00000000
01000068 00 0 00000000
0100006C 00 0 00000000
01000074 00 0 00000000
01000078 00 0 00000000
01000080 00 0 00000000
01000084 00 0 00000000
0100008C 00 0 00000000
01000090 00 0 00000000
01000098 00 0 00000000
0100009C 00 0 00000000
010000A4 18 1 00000003
010000A8 18 1 00000002
010000AC 00 0 00000000
010000A8 18 1 00000001
010000AC 00 0 00000000
010000A8 18 1 00000000
010000AC 00 0 00000000
@0F0
0000002A

// ==== pd_core.f ====
hdl/core_pkg.sv
hdl/decode_if.sv
hdl/pc_counter.sv
hdl/core_sequencer.sv
hdl/insn_memory.sv
hdl/decode.sv
hdl/register_file.sv
hdl/alu.sv
hdl/pd_core.sv
tests/clk_gen.sv
tests/pd_core_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the core testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
  --top-module pd_core_tb \
  -f pd_core.f \
  -o pd_core_sim

./obj_dir/pd_core_sim | tee sim.log

if grep -q "Testbench passed" sim.log; then
  echo "Simulation PASS"
  exit 0
else
  echo "Simulation FAIL"
  exit 1
fi
